/* source/pad_pkg.sv */
// shared types and ids for the game controller report path
// vid/pid constants are packed as {vid, pid}
`default_nettype none

package pad_pkg;

    // controller families told apart by vid/pid
    typedef enum logic [1:0] {
        DEV_GENERIC     = 2'd0,
        DEV_GAMEPAD     = 2'd1,
        DEV_DS2_ADAPTER = 2'd2
    } dev_type_e;

    // decoded controller state, x and y feed auto-fire
    typedef struct packed {
        logic right;
        logic left;
        logic down;
        logic up;
        logic start;
        logic select;
        logic b;
        logic a;
        logic x;
        logic y;
    } pad_buttons_t;

    // nes-style output byte
    typedef struct packed {
        logic right;
        logic left;
        logic down;
        logic up;
        logic start;
        logic select;
        logic b;
        logic a;
    } nes_buttons_t;

    typedef struct packed {
        pad_buttons_t buttons;
        logic         alt_record;  // byte 0 low bits were 2'b10
    } pad_report_t;

    localparam logic [31:0] GAMEPAD_VID_PID     = 32'h081F_E401;  // snes-style pad
    localparam logic [31:0] DS2_ADAPTER_VID_PID = 32'h0810_0001;  // dualshock-2 usb adapter

endpackage

`default_nettype wire

/* source/report_decoder.sv */
// decodes up to eight bytes per frame into controller state
// strobes are one cycle wide, bytes past the eighth are dropped
`default_nettype none

module report_decoder (
    input  wire                  usbclk,
    input  wire                  usbrst_n,
    input  wire                  frame_active,
    input  wire                  byte_stb,
    input  wire [7:0]            byte_data,
    output pad_pkg::pad_report_t report,
    output logic                 report_valid,
    output logic [63:0]          hid_report
);

    logic [3:0]            byte_idx;     // strobes seen since frame start
    logic                  active_q;     // frame_active, one cycle late
    logic                  alt_q;        // current frame is an alt record
    logic                  take_byte;
    logic                  frame_end;
    pad_pkg::pad_buttons_t btn_q;

    assign take_byte = byte_stb && frame_active && !byte_idx[3];
    assign frame_end = active_q && !frame_active;

    // byte index and raw frame capture
    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            byte_idx   <= 4'd0;
            hid_report <= 64'd0;
        end else if (!frame_active) begin
            byte_idx <= 4'd0;
        end else if (take_byte) begin
            hid_report[{byte_idx[2:0], 3'b000} +: 8] <= byte_data;
            byte_idx <= byte_idx + 4'd1;
        end
    end

    // field decode, later assignments in a step win
    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            btn_q <= '0;
            alt_q <= 1'b0;
        end else if (take_byte) begin
            case (byte_idx[2:0])
                3'd0: begin
                    if (byte_data[1:0] == 2'b10) begin
                        alt_q <= 1'b1;  // irrelevant ds2 adapter record
                    end else begin
                        alt_q       <= 1'b0;
                        btn_q.left  <= 1'b0;
                        btn_q.right <= 1'b0;
                        btn_q.up    <= 1'b0;
                        btn_q.down  <= 1'b0;
                    end
                    if (byte_data == 8'h00)
                        {btn_q.left, btn_q.right} <= 2'b10;
                    else if (byte_data == 8'hFF)
                        {btn_q.left, btn_q.right} <= 2'b01;
                end
                3'd1: begin
                    if (byte_data == 8'h00)
                        {btn_q.up, btn_q.down} <= 2'b10;
                    else if (byte_data == 8'hFF)
                        {btn_q.up, btn_q.down} <= 2'b01;
                end
                3'd3: if (!alt_q) begin
                    // x axis, only the top two bits matter
                    if (byte_data[7:6] == 2'b00)
                        {btn_q.left, btn_q.right} <= 2'b10;
                    else if (byte_data[7:6] == 2'b11)
                        {btn_q.left, btn_q.right} <= 2'b01;
                end
                3'd4: if (!alt_q) begin
                    if (byte_data[7:6] == 2'b00)
                        {btn_q.up, btn_q.down} <= 2'b10;
                    else if (byte_data[7:6] == 2'b11)
                        {btn_q.up, btn_q.down} <= 2'b01;
                end
                3'd5: if (!alt_q) begin
                    btn_q.x <= byte_data[4];
                    btn_q.a <= byte_data[5];
                    btn_q.b <= byte_data[6];
                    btn_q.y <= byte_data[7];
                end
                3'd6: if (!alt_q) begin
                    btn_q.select <= byte_data[4];
                    btn_q.start  <= byte_data[5];
                end
                default: ;  // bytes 2 and 7 carry nothing we use
            endcase
        end
    end

    // end of frame pulse
    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            active_q     <= 1'b0;
            report_valid <= 1'b0;
        end else begin
            active_q     <= frame_active;
            report_valid <= frame_end;
        end
    end

    always_ff @(posedge usbclk) begin
        if (frame_end) begin
            report.buttons    <= btn_q;
            report.alt_record <= alt_q;
        end
    end

endmodule

`default_nettype wire

/* source/device_identifier.sv */
// picks vid/pid from bytes 0-3 of each frame, little-endian
// published and classified only on vidpid_stb
`default_nettype none

module device_identifier (
    input  wire                usbclk,
    input  wire                usbrst_n,
    input  wire                frame_active,
    input  wire                byte_stb,
    input  wire [7:0]          byte_data,
    input  wire                vidpid_stb,
    output pad_pkg::dev_type_e dev_type,
    output logic [15:0]        vid,
    output logic [15:0]        pid
);

    logic [1:0]         cap_idx;
    logic               cap_done;   // bytes 0-3 already taken
    logic [31:0]        cand;       // {pid_hi, pid_lo, vid_hi, vid_lo}
    logic               take_byte;
    pad_pkg::dev_type_e dev_next;

    assign take_byte = byte_stb && frame_active && !cap_done;

    always_ff @(posedge usbclk) begin
        if (!usbrst_n || !frame_active) begin
            cap_idx  <= 2'd0;
            cap_done <= 1'b0;
        end else if (take_byte) begin
            cap_idx <= cap_idx + 2'd1;
            if (cap_idx == 2'd3)
                cap_done <= 1'b1;
        end
    end

    always_ff @(posedge usbclk) begin
        if (take_byte)
            cand[{cap_idx, 3'b000} +: 8] <= byte_data;
    end

    always_comb begin
        case ({cand[15:0], cand[31:16]})
            pad_pkg::GAMEPAD_VID_PID:     dev_next = pad_pkg::DEV_GAMEPAD;
            pad_pkg::DS2_ADAPTER_VID_PID: dev_next = pad_pkg::DEV_DS2_ADAPTER;
            default:                      dev_next = pad_pkg::DEV_GENERIC;
        endcase
    end

    // publish the candidate from the last frame
    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            vid      <= 16'd0;
            pid      <= 16'd0;
            dev_type <= pad_pkg::DEV_GENERIC;
        end else if (vidpid_stb) begin
            vid      <= cand[15:0];
            pid      <= cand[31:16];
            dev_type <= dev_next;
        end
    end

endmodule

`default_nettype wire

/* source/pad_mapper.sv */
// maps decoded reports to the nes button byte, with auto-fire on x and y
// auto-fire advances per accepted report, not per unit of time
`default_nettype none

module pad_mapper #(
    parameter int AUTOFIRE_PERIOD = 4
) (
    input  wire                    usbclk,
    input  wire                    usbrst_n,
    input  pad_pkg::pad_report_t   report,
    input  wire                    report_valid,
    input  pad_pkg::dev_type_e     dev_type,
    output pad_pkg::nes_buttons_t  nes_buttons
);

    localparam int CNT_W = (AUTOFIRE_PERIOD > 1) ? $clog2(AUTOFIRE_PERIOD) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(AUTOFIRE_PERIOD - 1);

    logic             accept;
    logic [1:0]       hold;              // index 0 is x, 1 is y
    logic [1:0]       phase;             // 0 drives a, 1 drives b
    logic [CNT_W-1:0] fire_cnt [2];

    // ds2 adapter sends a second record type that carries no pad state
    assign accept = report_valid &&
                    !(dev_type == pad_pkg::DEV_DS2_ADAPTER && report.alt_record);

    assign hold = {report.buttons.y, report.buttons.x};

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            nes_buttons <= '0;
        end else if (accept) begin
            nes_buttons.right  <= report.buttons.right;
            nes_buttons.left   <= report.buttons.left;
            nes_buttons.down   <= report.buttons.down;
            nes_buttons.up     <= report.buttons.up;
            nes_buttons.start  <= report.buttons.start;
            nes_buttons.select <= report.buttons.select;
            nes_buttons.b      <= report.buttons.b | phase[1];  // phase before update
            nes_buttons.a      <= report.buttons.a | phase[0];
        end
    end

    // one counter and phase per fire button
    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            phase <= 2'b00;
            for (int i = 0; i < 2; i++)
                fire_cnt[i] <= '0;
        end else if (accept) begin
            for (int i = 0; i < 2; i++) begin
                if (!hold[i]) begin
                    fire_cnt[i] <= '0;          // released, restart from off
                    phase[i]    <= 1'b0;
                end else if (fire_cnt[i] == CNT_LAST) begin
                    fire_cnt[i] <= '0;
                    phase[i]    <= ~phase[i];
                end else begin
                    fire_cnt[i] <= fire_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/usb_pad_host.sv */
// report side of a usb game controller host, fed by an external sequencer
// all inputs are single-cycle strobes or levels in the usbclk domain
`default_nettype none

module usb_pad_host #(
    parameter int AUTOFIRE_PERIOD = 4   // accepted reports per auto-fire phase
) (
    input  wire                   usbclk,
    input  wire                   usbrst_n,
    input  wire                   frame_active,
    input  wire                   byte_stb,
    input  wire [7:0]             byte_data,
    input  wire                   vidpid_stb,
    output pad_pkg::nes_buttons_t nes_buttons,
    output pad_pkg::dev_type_e    dev_type,
    output logic [15:0]           vid,
    output logic [15:0]           pid,
    output logic [63:0]           hid_report
);

    pad_pkg::pad_report_t report;
    logic                 report_valid;

    report_decoder u_report_decoder (
        .usbclk       (usbclk),
        .usbrst_n     (usbrst_n),
        .frame_active (frame_active),
        .byte_stb     (byte_stb),
        .byte_data    (byte_data),
        .report       (report),
        .report_valid (report_valid),
        .hid_report   (hid_report)
    );

    // runs on the same byte stream, side by side with the decoder
    device_identifier u_device_identifier (
        .usbclk       (usbclk),
        .usbrst_n     (usbrst_n),
        .frame_active (frame_active),
        .byte_stb     (byte_stb),
        .byte_data    (byte_data),
        .vidpid_stb   (vidpid_stb),
        .dev_type     (dev_type),
        .vid          (vid),
        .pid          (pid)
    );

    pad_mapper #(
        .AUTOFIRE_PERIOD (AUTOFIRE_PERIOD)
    ) u_pad_mapper (
        .usbclk       (usbclk),
        .usbrst_n     (usbrst_n),
        .report       (report),
        .report_valid (report_valid),
        .dev_type     (dev_type),
        .nes_buttons  (nes_buttons)
    );

endmodule

`default_nettype wire

/* sim/usb_pad_host_props.sv */
// pulse and update-timing properties, bound into usb_pad_host
// fail_count is read back by the testbench at the end of the run
`default_nettype none

module usb_pad_host_props (
    input wire                   usbclk,
    input wire                   usbrst_n,
    input wire                   report_valid,
    input wire                   vidpid_stb,
    input pad_pkg::dev_type_e    dev_type,
    input pad_pkg::nes_buttons_t nes_buttons
);

    int fail_count = 0;

    // end of frame gives a single-cycle pulse
    report_valid_single: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        report_valid |=> !report_valid)
    else begin
        $error("report_valid stayed high for two cycles");
        fail_count++;
    end

    dev_type_on_vidpid: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        $changed(dev_type) |-> $past(vidpid_stb))
    else begin
        $error("dev_type changed without vidpid_stb");
        fail_count++;
    end

    nes_on_report: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        $changed(nes_buttons) |-> $past(report_valid))  // one cycle after the pulse
    else begin
        $error("nes_buttons changed without report_valid");
        fail_count++;
    end

endmodule

bind usb_pad_host usb_pad_host_props u_props (
    .usbclk       (usbclk),
    .usbrst_n     (usbrst_n),
    .report_valid (report_valid),
    .vidpid_stb   (vidpid_stb),
    .dev_type     (dev_type),
    .nes_buttons  (nes_buttons)
);

`default_nettype wire

/* sim/usb_pad_host_tb.sv */
// frame table is built at time zero, all frames carry full or partial byte runs
// results are checked three cycles after frame_active falls
`default_nettype none

module usb_pad_host_tb;

    localparam int AF_PERIOD = 4;
    // expected a bit per auto-fire frame, x held for the first twelve
    localparam logic [13:0] FIRE_A = 14'h10F0;

    typedef struct packed {
        logic [63:0]           bytes;    // byte 0 in bits 7:0
        logic [3:0]            count;
        logic                  vidpid;   // pulse vidpid_stb after the frame
        pad_pkg::nes_buttons_t exp_nes;
        pad_pkg::dev_type_e    exp_dev;
        logic [15:0]           exp_vid;
        logic [15:0]           exp_pid;
        logic [63:0]           exp_hid;
    } frame_entry_t;

    logic                  usbclk;
    logic                  usbrst_n;
    logic                  frame_active;
    logic                  byte_stb;
    logic [7:0]            byte_data;
    logic                  vidpid_stb;
    pad_pkg::nes_buttons_t nes_buttons;
    pad_pkg::dev_type_e    dev_type;
    logic [15:0]           vid;
    logic [15:0]           pid;
    logic [63:0]           hid_report;

    frame_entry_t frames[$];
    integer       seed = 32'h9ed24918;
    int           errors = 0;
    int           cycles = 0;

    usb_pad_host #(
        .AUTOFIRE_PERIOD (AF_PERIOD)
    ) u_usb_pad_host (
        .usbclk       (usbclk),
        .usbrst_n     (usbrst_n),
        .frame_active (frame_active),
        .byte_stb     (byte_stb),
        .byte_data    (byte_data),
        .vidpid_stb   (vidpid_stb),
        .nes_buttons  (nes_buttons),
        .dev_type     (dev_type),
        .vid          (vid),
        .pid          (pid),
        .hid_report   (hid_report)
    );

    initial begin
        usbclk = 1'b0;
        forever #5 usbclk = ~usbclk;
    end

    // worst case frame is well under 40 cycles
    always @(posedge usbclk) begin
        cycles = cycles + 1;
        if (cycles > frames.size() * 40 + 100) begin
            $display("timeout: run did not finish within %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic add_frame(input logic [63:0] bytes, input logic [3:0] count,
                             input logic vidpid, input pad_pkg::nes_buttons_t exp_nes,
                             input pad_pkg::dev_type_e exp_dev, input logic [15:0] exp_vid,
                             input logic [15:0] exp_pid, input logic [63:0] exp_hid);
        frames.push_back('{bytes, count, vidpid, exp_nes, exp_dev, exp_vid, exp_pid, exp_hid});
    endtask

    // one strobe per byte with a random idle gap after it
    task automatic apply_frame(input frame_entry_t f);
        logic [3:0] idx;
        int         gap;
        @(negedge usbclk);
        frame_active = 1'b1;
        for (idx = 4'd0; idx < f.count; idx = idx + 4'd1) begin
            gap = $unsigned($random(seed)) % 3;
            @(negedge usbclk);
            byte_stb  = 1'b1;
            byte_data = f.bytes[{idx[2:0], 3'b000} +: 8];
            @(negedge usbclk);
            byte_stb = 1'b0;
            repeat (gap) @(negedge usbclk);
        end
        frame_active = 1'b0;
        @(negedge usbclk);
        vidpid_stb = f.vidpid;
        @(negedge usbclk);
        vidpid_stb = 1'b0;
        @(negedge usbclk);
    endtask

    task automatic check_nes(input pad_pkg::nes_buttons_t exp, input pad_pkg::nes_buttons_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t nes_buttons expected %02h actual %02h", $time, exp, act);
        end
    endtask

    task automatic check_dev(input pad_pkg::dev_type_e exp, input pad_pkg::dev_type_e act);
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t dev_type expected %s actual %s", $time, exp.name(), act.name());
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t %s expected %04h actual %04h", $time, name, exp, act);
        end
    endtask

    task automatic check_report(input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERR t=%0t hid_report expected %016h actual %016h", $time, exp, act);
        end
    endtask

    initial begin
        usbrst_n     = 1'b0;
        frame_active = 1'b0;
        byte_stb     = 1'b0;
        byte_data    = 8'h00;
        vidpid_stb   = 1'b0;

        // generic decode, then axes from bytes 0 and 1
        add_frame(64'h0020_6000_0000_8001, 4'd8, 1'b0, 8'h5B, pad_pkg::DEV_GENERIC,
                  16'h0000, 16'h0000, 64'h0020_6000_0000_8001);
        add_frame(64'h0000_0080_8000_00FF, 4'd8, 1'b0, 8'h90, pad_pkg::DEV_GENERIC,
                  16'h0000, 16'h0000, 64'h0000_0080_8000_00FF);
        // short descriptor frame, upper bytes of hid_report are kept
        add_frame(64'h0000_0000_E401_081F, 4'd4, 1'b1, 8'h80, pad_pkg::DEV_GAMEPAD,
                  16'h081F, 16'hE401, 64'h0000_0080_E401_081F);
        add_frame(64'h0010_0FFF_FF00_8001, 4'd8, 1'b0, 8'hA4, pad_pkg::DEV_GAMEPAD,
                  16'h081F, 16'hE401, 64'h0010_0FFF_FF00_8001);
        add_frame(64'h0000_0080_0001_0810, 4'd8, 1'b1, 8'h40, pad_pkg::DEV_DS2_ADAPTER,
                  16'h0810, 16'h0001, 64'h0000_0080_0001_0810);
        // alt record dropped under the adapter
        add_frame(64'h0020_6000_0000_0002, 4'd8, 1'b0, 8'h40, pad_pkg::DEV_DS2_ADAPTER,
                  16'h0810, 16'h0001, 64'h0020_6000_0000_0002);
        add_frame(64'h0000_0080_5678_1234, 4'd8, 1'b1, 8'h00, pad_pkg::DEV_GENERIC,
                  16'h1234, 16'h5678, 64'h0000_0080_5678_1234);
        add_frame(64'h0020_6000_0000_0002, 4'd8, 1'b0, 8'h10, pad_pkg::DEV_GENERIC,
                  16'h1234, 16'h5678, 64'h0020_6000_0000_0002);
        for (int i = 0; i < 14; i++) begin
            if (i < 12)
                add_frame(64'h0000_1080_8000_8001, 4'd8, 1'b0, {7'd0, FIRE_A[i]},
                          pad_pkg::DEV_GENERIC, 16'h1234, 16'h5678, 64'h0000_1080_8000_8001);
            else
                add_frame(64'h0000_0080_8000_8001, 4'd8, 1'b0, {7'd0, FIRE_A[i]},
                          pad_pkg::DEV_GENERIC, 16'h1234, 16'h5678, 64'h0000_0080_8000_8001);
        end

        repeat (4) @(posedge usbclk);
        @(negedge usbclk);
        usbrst_n = 1'b1;
        @(negedge usbclk);
        check_nes(8'h00, nes_buttons);  // reset state, no frame yet
        check_dev(pad_pkg::DEV_GENERIC, dev_type);
        check_word("vid", 16'h0000, vid);
        check_word("pid", 16'h0000, pid);
        check_report(64'd0, hid_report);

        foreach (frames[i]) begin
            apply_frame(frames[i]);
            check_nes(frames[i].exp_nes, nes_buttons);
            check_dev(frames[i].exp_dev, dev_type);
            check_word("vid", frames[i].exp_vid, vid);
            check_word("pid", frames[i].exp_pid, pid);
            check_report(frames[i].exp_hid, hid_report);
        end

        $display("done: %0d frames, %0d check errors, %0d assertion failures",
                 frames.size(), errors, u_usb_pad_host.u_props.fail_count);
        if (errors == 0 && u_usb_pad_host.u_props.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
source/pad_pkg.sv
source/report_decoder.sv
source/device_identifier.sv
source/pad_mapper.sv
source/usb_pad_host.sv
sim/usb_pad_host_props.sv
sim/usb_pad_host_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := usb_pad_host_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# a high error limit lets the testbench print its own verdict
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
